// File: logic/uart_ctrl.sv
// Single clock tcb_wrc, 8N1 only; both bus channels always ready, full FIFOs drop bytes
`timescale 1ns/1ps

module uart_ctrl (
  input  logic              tcb_wrc,
  input  logic              rst_n,
  // Register channels
  input  uart_pkg::wr_req_t wr_req,
  input  uart_pkg::rd_req_t rd_req,
  output uart_pkg::rd_rsp_t rd_rsp,
  // Serial line
  input  logic              uart_rxd,
  output logic              uart_txd,
  // Level interrupts
  output logic              irq_tx,  // TX load below threshold
  output logic              irq_rx   // RX load above threshold
);

  import uart_pkg::*;

  // Configuration
  logic [BW-1:0] tx_bdr, rx_bdr;  // Bit periods minus one
  logic [BW-1:0] rx_smp;          // RX sample phase
  logic [CW-1:0] tx_irq, rx_irq;  // Thresholds
  // FIFO loads
  logic [CW-1:0] tx_cnt, rx_cnt;
  // Bus side streams
  byte_str_t     tx_bus, rx_bus;
  logic          tx_bus_rdy, rx_bus_rdy;
  // Line side streams
  byte_str_t     tx_str, rx_str;
  logic          tx_str_rdy;

  //////////////////////////////////////////////////////////////////////
  // Write channel
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb_wrc) begin
    if (!rst_n) begin
      tx_bdr <= RST_BDR;
      tx_irq <= RST_IRQ;
      rx_bdr <= RST_BDR;
      rx_smp <= RST_SMP;
      rx_irq <= RST_IRQ;
    end else if (wr_req.vld) begin
      case (wr_req.adr)
        ADR_TX_BDR: tx_bdr <= wr_req.wdt[BW-1:0];
        ADR_TX_IRQ: tx_irq <= wr_req.wdt[CW-1:0];
        ADR_RX_BDR: rx_bdr <= wr_req.wdt[BW-1:0];
        ADR_RX_SMP: rx_smp <= wr_req.wdt[BW-1:0];
        ADR_RX_IRQ: rx_irq <= wr_req.wdt[CW-1:0];
        default:    ;  // Counts and holes ignored
      endcase
    end
  end

  // TX data push drops the byte when the FIFO is full
  assign tx_bus.vld = wr_req.vld & (wr_req.adr == ADR_TX_DAT) & tx_bus_rdy;
  assign tx_bus.dat = wr_req.wdt[DW-1:0];

  //////////////////////////////////////////////////////////////////////
  // Read channel
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (rd_req.adr)
      ADR_TX_CNT: rd_rsp.rdt = 32'(tx_cnt);
      ADR_TX_BDR: rd_rsp.rdt = 32'(tx_bdr);
      ADR_TX_IRQ: rd_rsp.rdt = 32'(tx_irq);
      ADR_RX_DAT: rd_rsp.rdt = rx_bus.vld ? 32'(rx_bus.dat) : '0;  // Empty reads 0
      ADR_RX_CNT: rd_rsp.rdt = 32'(rx_cnt);
      ADR_RX_BDR: rd_rsp.rdt = 32'(rx_bdr);
      ADR_RX_SMP: rd_rsp.rdt = 32'(rx_smp);
      ADR_RX_IRQ: rd_rsp.rdt = 32'(rx_irq);
      default:    rd_rsp.rdt = '0;  // TX data and holes
    endcase
  end

  // Valid data read pops the RX FIFO unless it is empty
  assign rx_bus_rdy = rd_req.vld & (rd_req.adr == ADR_RX_DAT);

  //////////////////////////////////////////////////////////////////////
  // TX path
  //////////////////////////////////////////////////////////////////////

  uart_fifo tx_fifo (
    .tcb_wrc (tcb_wrc),
    .rst_n   (rst_n),
    .sti     (tx_bus),
    .sti_rdy (tx_bus_rdy),
    .sto     (tx_str),
    .sto_rdy (tx_str_rdy),  // Drains only when serializer idle
    .cnt     (tx_cnt)
  );

  uart_ser tx_ser (
    .tcb_wrc (tcb_wrc),
    .rst_n   (rst_n),
    .cfg_bdr (tx_bdr),
    .str     (tx_str),
    .str_rdy (tx_str_rdy),
    .txd     (uart_txd)
  );

  //////////////////////////////////////////////////////////////////////
  // RX path
  //////////////////////////////////////////////////////////////////////

  uart_des rx_des (
    .tcb_wrc (tcb_wrc),
    .rst_n   (rst_n),
    .cfg_bdr (rx_bdr),
    .cfg_smp (rx_smp),
    .rxd     (uart_rxd),
    .str     (rx_str)
  );

  uart_fifo rx_fifo (
    .tcb_wrc (tcb_wrc),
    .rst_n   (rst_n),
    .sti     (rx_str),
    .sti_rdy (),  // No back-pressure into the deserializer
    .sto     (rx_bus),
    .sto_rdy (rx_bus_rdy),
    .cnt     (rx_cnt)
  );

  // Interrupt levels
  assign irq_tx = (tx_cnt < tx_irq);
  assign irq_rx = (rx_cnt > rx_irq);

endmodule: uart_ctrl

// File: logic/uart_des.sv
// 8N1 only; cfg_smp must not exceed cfg_bdr, sampling lags the line by the 2-flop sync
`timescale 1ns/1ps

module uart_des (
  input  logic                    tcb_wrc,
  input  logic                    rst_n,
  input  logic [uart_pkg::BW-1:0] cfg_bdr,  // Cycles per bit minus one
  input  logic [uart_pkg::BW-1:0] cfg_smp,  // Sample offset in bit
  input  logic                    rxd,
  output uart_pkg::byte_str_t     str
);

  import uart_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Input synchronizer
  //////////////////////////////////////////////////////////////////////

  logic [2:0]    rxd_sync;  // Two sync flops plus edge history
  logic          rxd_s;     // Synchronized line
  logic          fall;      // Start of a possible start bit
  logic          busy;      // Frame in progress
  logic          vld;       // Byte ready pulse
  logic [BW-1:0] cnt_bdr;   // Cycle within current bit
  logic [3:0]    cnt_bit;   // 0 start, 1..DW data, DW+1 stop
  logic [DW-1:0] sft;       // Received data, LSB first
  logic          smp;       // Sample strobe

  assign rxd_s = rxd_sync[1];
  assign fall  = rxd_sync[2] & ~rxd_sync[1];
  assign smp   = busy & (cnt_bdr == cfg_smp);

  always_ff @(posedge tcb_wrc) begin
    if (!rst_n) begin
      rxd_sync <= '1;  // Idle line, no false edge out of reset
    end else begin
      rxd_sync <= {rxd_sync[1:0], rxd};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Frame control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb_wrc) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      vld     <= 1'b0;
      cnt_bdr <= '0;
      cnt_bit <= '0;
    end else begin
      vld <= 1'b0;  // One cycle pulse
      if (!busy) begin
        if (fall) begin
          busy    <= 1'b1;
          cnt_bdr <= '0;
          cnt_bit <= '0;
        end
      end else begin
        // Bit period
        if (cnt_bdr == cfg_bdr) begin
          cnt_bdr <= '0;
          cnt_bit <= cnt_bit + 1'b1;
        end else begin
          cnt_bdr <= cnt_bdr + 1'b1;
        end
        if (smp) begin
          if ((cnt_bit == '0) && rxd_s) begin
            busy <= 1'b0;  // Glitch, not a start bit
          end else if (cnt_bit == 4'(DW + 1)) begin
            busy <= 1'b0;   // Free again mid stop bit
            vld  <= rxd_s;  // Framing error drops the byte
          end
        end
      end
    end
  end

  // Data bits shift in from the top
  always_ff @(posedge tcb_wrc) begin
    if (smp && (cnt_bit != '0) && (cnt_bit <= 4'(DW))) begin
      sft <= {rxd_s, sft[DW-1:1]};
    end
  end

  assign str.vld = vld;
  assign str.dat = sft;  // Held until next frame's data bits

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // At most one byte per frame
  a_vld_pulse: assert property (
    @(posedge tcb_wrc) disable iff (!rst_n)
    str.vld |=> !str.vld
  ) else $error("Deserializer valid held two cycles");

endmodule: uart_des

// File: logic/uart_fifo.sv
// Depth FIFO_SZ must be a power of two, pointers wrap by overflow; no output register
`timescale 1ns/1ps

module uart_fifo (
  input  logic                    tcb_wrc,
  input  logic                    rst_n,
  // Write side
  input  uart_pkg::byte_str_t     sti,
  output logic                    sti_rdy,
  // Read side
  output uart_pkg::byte_str_t     sto,
  input  logic                    sto_rdy,
  // Load
  output logic [uart_pkg::CW-1:0] cnt
);

  import uart_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Storage and pointers
  //////////////////////////////////////////////////////////////////////

  logic [DW-1:0]              mem [FIFO_SZ];  // Byte array
  logic [$clog2(FIFO_SZ)-1:0] wr_ptr;         // Next free slot
  logic [$clog2(FIFO_SZ)-1:0] rd_ptr;         // Oldest entry
  logic                       push;
  logic                       pop;

  // Handshakes
  assign push = sti.vld & sti_rdy;
  assign pop  = sto.vld & sto_rdy;

  // Flags straight from the load count
  assign sti_rdy = (cnt != CW'(FIFO_SZ));  // Low while full
  assign sto.vld = (cnt != '0);            // High while not empty

  // Head of queue, valid the cycle after the first push
  assign sto.dat = mem[rd_ptr];

  always_ff @(posedge tcb_wrc) begin
    if (push) begin
      mem[wr_ptr] <= sti.dat;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pointer and load update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb_wrc) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at FIFO_SZ
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      // Load moves only when exactly one side transfers
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;  // Idle or push and pop together
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Pointer wrap and load stay consistent over any push/pop history
  a_cnt_max: assert property (
    @(posedge tcb_wrc) disable iff (!rst_n)
    cnt <= CW'(FIFO_SZ)
  ) else $error("FIFO load above depth");

endmodule: uart_fifo

// File: logic/uart_pkg.sv
// Fixed 8N1 frames only; FIFO_SZ must be a power of two and CW wide enough to hold FIFO_SZ
package uart_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned DW      = 8;   // Data bits per frame
  localparam int unsigned BW      = 16;  // Baud and sample counters
  localparam int unsigned FIFO_SZ = 16;  // Entries per FIFO
  localparam int unsigned CW      = 5;   // Load count, 0..FIFO_SZ
  localparam int unsigned AW      = 6;   // Register offset

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  // TX side
  localparam logic [AW-1:0] ADR_TX_DAT = 6'h00;  // Push into TX FIFO
  localparam logic [AW-1:0] ADR_TX_CNT = 6'h04;  // TX load, read only
  localparam logic [AW-1:0] ADR_TX_BDR = 6'h08;  // Bit period minus one
  localparam logic [AW-1:0] ADR_TX_IRQ = 6'h10;  // Low-water threshold
  // RX side
  localparam logic [AW-1:0] ADR_RX_DAT = 6'h20;  // Pop from RX FIFO
  localparam logic [AW-1:0] ADR_RX_CNT = 6'h24;  // RX load, read only
  localparam logic [AW-1:0] ADR_RX_BDR = 6'h28;  // Bit period minus one
  localparam logic [AW-1:0] ADR_RX_SMP = 6'h2C;  // Sample point in bit
  localparam logic [AW-1:0] ADR_RX_IRQ = 6'h30;  // High-water threshold

  // Reset values of the configuration registers
  localparam logic [BW-1:0] RST_BDR = 16'd15;  // 16 cycles per bit
  localparam logic [BW-1:0] RST_SMP = 16'd7;   // Mid bit
  localparam logic [CW-1:0] RST_IRQ = 5'd0;

  //////////////////////////////////////////////////////////////////////
  // Bus and stream types
  //////////////////////////////////////////////////////////////////////

  // Write request, takes effect on the edge where vld is high
  typedef struct packed {
    logic          vld;
    logic [AW-1:0] adr;
    logic [31:0]   wdt;
  } wr_req_t;

  // Read request, data returned in the same cycle
  typedef struct packed {
    logic          vld;  // Only qualifies the RX pop
    logic [AW-1:0] adr;
  } rd_req_t;

  typedef struct packed {
    logic [31:0] rdt;
  } rd_rsp_t;

  // Byte stream, rdy runs alongside in the other direction
  typedef struct packed {
    logic          vld;
    logic [DW-1:0] dat;
  } byte_str_t;

endpackage: uart_pkg

// File: logic/uart_ser.sv
// 8N1 only, LSB first; takes one byte per frame and idles one cycle between frames
`timescale 1ns/1ps

module uart_ser (
  input  logic                    tcb_wrc,
  input  logic                    rst_n,
  input  logic [uart_pkg::BW-1:0] cfg_bdr,  // Cycles per bit minus one
  input  uart_pkg::byte_str_t     str,
  output logic                    str_rdy,
  output logic                    txd
);

  import uart_pkg::*;

  logic          busy;     // Frame in progress
  logic [BW-1:0] cnt_bdr;  // Cycle within current bit
  logic [3:0]    cnt_bit;  // Bits still to send after the current one
  logic [DW:0]   sft;      // Data bits then stop bit
  logic          bit_end;  // Last cycle of a bit

  assign str_rdy = ~busy;
  assign bit_end = (cnt_bdr == cfg_bdr);

  //////////////////////////////////////////////////////////////////////
  // Bit timing and line driver
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb_wrc) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      cnt_bdr <= '0;
      cnt_bit <= '0;
      txd     <= 1'b1;  // Line idles high
    end else if (!busy) begin
      if (str.vld) begin
        busy    <= 1'b1;
        cnt_bdr <= '0;
        cnt_bit <= 4'(DW + 1);  // Data plus stop
        txd     <= 1'b0;        // Start bit on the next edge
      end
    end else if (bit_end) begin
      cnt_bdr <= '0;
      if (cnt_bit != '0) begin
        txd     <= sft[0];  // Next bit out
        cnt_bit <= cnt_bit - 1'b1;
      end else begin
        busy <= 1'b0;  // Stop bit done, txd already high
      end
    end else begin
      cnt_bdr <= cnt_bdr + 1'b1;
    end
  end

  // Payload shift, stop bit enters at the top
  always_ff @(posedge tcb_wrc) begin
    if (str.vld & str_rdy) begin
      sft <= {1'b1, str.dat};
    end else if (busy & bit_end) begin
      sft <= {1'b1, sft[DW:1]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Each frame must leave the line at the stop level
  a_idle_high: assert property (
    @(posedge tcb_wrc) disable iff (!rst_n)
    !busy |-> txd
  ) else $error("txd low while serializer idle");

endmodule: uart_ser

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the UART testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module uart_tb -o uart_tb_sim \
  && ./obj_dir/uart_tb_sim | tee sim.log \
  && grep -qx "sim passed" sim.log \
  || { echo "Simulation did not pass, see sim.log"; exit 1; }

// File: tb.f
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_ser.sv
logic/uart_des.sv
logic/uart_ctrl.sv
verif/uart_tb_clk.sv
verif/uart_tb.sv

// File: verif/uart_tb.sv
// Loopback test, TX and RX baud kept equal; burst test assumes 17 writes finish within one frame
`timescale 1ns/1ps

module uart_tb;

  import uart_pkg::*;

  localparam int TB_BDR  = 3;  // Bit period minus one in traffic tests
  localparam int TB_SMP  = 1;
  localparam int BATCH   = 5;  // Bytes per batch, fits one serializer plus FIFO
  localparam int N_BATCH = 4;  // 20 bytes total
  localparam int N_BURST = 17;
  // Frames times bits times bit period, idle cycle included, plus register traffic
  localparam int WD_CYC  = (BATCH * N_BATCH + N_BURST) * 10 * (TB_BDR + 2) + 4000;

  logic      tcb_wrc;
  logic      rst_n;
  wr_req_t   wr_req;
  rd_req_t   rd_req;
  rd_rsp_t   rd_rsp;
  logic      txd;  // Looped back into the receiver
  logic      irq_tx, irq_rx;
  // Compare process inputs
  logic          cmp_en;
  logic [AW-1:0] cmp_adr;
  rd_rsp_t       cmp_exp;
  // Register model
  logic [BW-1:0] m_tx_bdr, m_rx_bdr, m_rx_smp;
  logic [CW-1:0] m_tx_irq, m_rx_irq;
  int            m_tx_load;
  logic [DW-1:0] rx_q [$];  // Bytes expected in the RX FIFO
  int            err_cnt;
  int            chk_cnt;
  integer        seed;

  uart_tb_clk clk_gen (.tcb_wrc(tcb_wrc), .rst_n(rst_n));

  uart_ctrl uut (
    .tcb_wrc  (tcb_wrc),
    .rst_n    (rst_n),
    .wr_req   (wr_req),
    .rd_req   (rd_req),
    .rd_rsp   (rd_rsp),
    .uart_rxd (txd),
    .uart_txd (txd),
    .irq_tx   (irq_tx),
    .irq_rx   (irq_rx)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference and checks
  //////////////////////////////////////////////////////////////////////

  // Expected read data from the register map and the model state
  function automatic logic [31:0] ref_read(input logic [AW-1:0] adr);
    case (adr)
      ADR_TX_CNT: ref_read = 32'(m_tx_load);
      ADR_TX_BDR: ref_read = 32'(m_tx_bdr);
      ADR_TX_IRQ: ref_read = 32'(m_tx_irq);
      ADR_RX_DAT: ref_read = (rx_q.size() != 0) ? 32'(rx_q[0]) : 32'h0;  // Empty reads 0
      ADR_RX_CNT: ref_read = 32'(rx_q.size());
      ADR_RX_BDR: ref_read = 32'(m_rx_bdr);
      ADR_RX_SMP: ref_read = 32'(m_rx_smp);
      ADR_RX_IRQ: ref_read = 32'(m_rx_irq);
      default:    ref_read = 32'h0;  // TX data and holes
    endcase
  endfunction

  task automatic check_rsp(input rd_rsp_t exp, input rd_rsp_t act, input logic [AW-1:0] adr);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAILED %0t ns: read 0x%02h expected 0x%08h got 0x%08h",
               $time, adr, exp.rdt, act.rdt);
    end
  endtask

  // Bit order {irq_tx, irq_rx}, care masks bits not known at the sample point
  task automatic check_irq(input logic [1:0] exp, input logic [1:0] act,
                           input logic [1:0] care, input string what);
    chk_cnt++;
    if (((act ^ exp) & care) != 2'b00 || $isunknown(act & care)) begin
      err_cnt++;
      $display("FAILED %0t ns: %s irq expected %b got %b (mask %b)", $time, what, exp, act, care);
    end
  endtask

  task automatic check_line(input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAILED %0t ns: txd expected %b got %b", $time, exp, act);
    end
  endtask

  // Compare on the falling edge, read data settled by then
  always @(negedge tcb_wrc) begin
    if (cmp_en) check_rsp(cmp_exp, rd_rsp, cmp_adr);
  end

  //////////////////////////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic write_reg(input logic [AW-1:0] adr, input logic [31:0] wdt);
    @(posedge tcb_wrc);
    wr_req <= '{vld: 1'b1, adr: adr, wdt: wdt};
    @(posedge tcb_wrc);  // Write lands here
    wr_req.vld <= 1'b0;
    case (adr)  // Fields keep their low bits only
      ADR_TX_BDR: m_tx_bdr = wdt[BW-1:0];
      ADR_TX_IRQ: m_tx_irq = wdt[CW-1:0];
      ADR_RX_BDR: m_rx_bdr = wdt[BW-1:0];
      ADR_RX_SMP: m_rx_smp = wdt[BW-1:0];
      ADR_RX_IRQ: m_rx_irq = wdt[CW-1:0];
      default:    ;
    endcase
  endtask

  // cmp set: compare against the model, and pop the model on a data read
  task automatic read_reg(input logic [AW-1:0] adr, input bit cmp,
                          output logic [31:0] rdt, output logic [1:0] irq);
    @(posedge tcb_wrc);
    rd_req  <= '{vld: 1'b1, adr: adr};
    cmp_en  <= cmp;
    cmp_adr <= adr;
    cmp_exp <= '{rdt: ref_read(adr)};
    if (cmp && adr == ADR_RX_DAT && rx_q.size() != 0) void'(rx_q.pop_front());
    @(negedge tcb_wrc);
    rdt = rd_rsp.rdt;
    irq = {irq_tx, irq_rx};
    @(posedge tcb_wrc);  // Pop happens here
    rd_req.vld <= 1'b0;
    cmp_en     <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    repeat (WD_CYC) @(posedge tcb_wrc);
    $display("Timeout after %0d cycles, the test did not complete", WD_CYC);
    $display("sim failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]   rdt;
    logic [1:0]    irq;
    logic [DW-1:0] b;
    int            tx_held;
    wr_req    = '0;
    rd_req    = '0;
    cmp_en    = 1'b0;
    cmp_adr   = '0;
    cmp_exp   = '0;
    m_tx_bdr  = RST_BDR;
    m_rx_bdr  = RST_BDR;
    m_rx_smp  = RST_SMP;
    m_tx_irq  = RST_IRQ;
    m_rx_irq  = RST_IRQ;
    m_tx_load = 0;
    err_cnt   = 0;
    chk_cnt   = 0;
    seed      = 84950;
    wait (rst_n === 1'b1);

    // Reset state
    read_reg(ADR_TX_BDR, 1'b1, rdt, irq);
    read_reg(ADR_TX_IRQ, 1'b1, rdt, irq);
    read_reg(ADR_RX_BDR, 1'b1, rdt, irq);
    read_reg(ADR_RX_SMP, 1'b1, rdt, irq);
    read_reg(ADR_RX_IRQ, 1'b1, rdt, irq);
    read_reg(ADR_TX_CNT, 1'b1, rdt, irq);
    read_reg(ADR_RX_CNT, 1'b1, rdt, irq);
    check_irq(2'b00, irq, 2'b11, "reset");
    check_line(1'b1, txd);

    // Readback with upper bits dropped
    write_reg(ADR_TX_BDR, 32'hABCD_0009);
    write_reg(ADR_RX_BDR, 32'h1234_0007);
    write_reg(ADR_RX_SMP, 32'h0000_8003);
    write_reg(ADR_TX_IRQ, 32'hFFFF_FFEA);
    write_reg(ADR_RX_IRQ, 32'h0000_0033);
    write_reg(ADR_TX_CNT, 32'h0000_0005);  // Ignored
    write_reg(6'h0C, 32'hFFFF_FFFF);       // Hole
    read_reg(ADR_TX_BDR, 1'b1, rdt, irq);
    read_reg(ADR_RX_BDR, 1'b1, rdt, irq);
    read_reg(ADR_RX_SMP, 1'b1, rdt, irq);
    read_reg(ADR_TX_IRQ, 1'b1, rdt, irq);
    read_reg(ADR_RX_IRQ, 1'b1, rdt, irq);
    read_reg(ADR_TX_CNT, 1'b1, rdt, irq);
    check_irq({32'(m_tx_load) < 32'(m_tx_irq), 1'b0}, irq, 2'b11, "config");
    read_reg(6'h0C, 1'b1, rdt, irq);
    read_reg(6'h14, 1'b1, rdt, irq);
    read_reg(6'h3C, 1'b1, rdt, irq);
    read_reg(ADR_TX_DAT, 1'b1, rdt, irq);

    // Traffic setup
    write_reg(ADR_TX_BDR, 32'(TB_BDR));
    write_reg(ADR_RX_BDR, 32'(TB_BDR));
    write_reg(ADR_RX_SMP, 32'(TB_SMP));
    write_reg(ADR_TX_IRQ, 32'd4);
    write_reg(ADR_RX_IRQ, 32'd2);

    // Random bytes in batches, levels watched while they move
    for (int k = 0; k < N_BATCH; k++) begin
      for (int i = 0; i < BATCH; i++) begin
        b = 8'($random(seed));
        write_reg(ADR_TX_DAT, 32'(b));
        rx_q.push_back(b);
      end
      do begin  // TX drain
        read_reg(ADR_TX_CNT, 1'b0, rdt, irq);
        check_irq({rdt < 32'(m_tx_irq), 1'b0}, irq, 2'b10, "tx level");
      end while (rdt != 32'h0);
      m_tx_load = 0;
      do begin  // RX fill, TX now stays empty
        read_reg(ADR_RX_CNT, 1'b0, rdt, irq);
        check_irq({32'h0 < 32'(m_tx_irq), rdt > 32'(m_rx_irq)}, irq, 2'b11, "rx level");
      end while (rdt < 32'(BATCH));
      read_reg(ADR_RX_CNT, 1'b1, rdt, irq);
      for (int i = 0; i < BATCH; i++) begin
        read_reg(ADR_RX_DAT, 1'b1, rdt, irq);
      end
    end
    read_reg(ADR_RX_CNT, 1'b1, rdt, irq);
    check_irq(2'b10, irq, 2'b11, "drained");

    // Burst, one byte to the serializer and FIFO_SZ into the TX FIFO
    tx_held = 0;
    for (int i = 0; i < N_BURST; i++) begin
      b = 8'($random(seed));
      write_reg(ADR_TX_DAT, 32'(b));
      if (tx_held < 1 + int'(FIFO_SZ)) begin
        tx_held++;
        if (rx_q.size() < int'(FIFO_SZ)) rx_q.push_back(b);  // Full RX drops the rest
      end
    end
    m_tx_load = tx_held - 1;
    read_reg(ADR_TX_CNT, 1'b1, rdt, irq);
    check_irq({32'(m_tx_load) < 32'(m_tx_irq), 1'b0}, irq, 2'b10, "burst");
    do begin
      read_reg(ADR_TX_CNT, 1'b0, rdt, irq);
    end while (rdt != 32'h0);
    m_tx_load = 0;
    repeat (12 * (TB_BDR + 1)) @(posedge tcb_wrc);  // Last frame plus sync delay
    read_reg(ADR_RX_CNT, 1'b1, rdt, irq);
    while (rx_q.size() != 0) begin
      read_reg(ADR_RX_DAT, 1'b1, rdt, irq);
    end
    read_reg(ADR_RX_DAT, 1'b1, rdt, irq);  // Empty FIFO
    read_reg(ADR_RX_DAT, 1'b1, rdt, irq);
    read_reg(ADR_RX_CNT, 1'b1, rdt, irq);
    check_irq(2'b10, irq, 2'b11, "end");
    check_line(1'b1, txd);

    repeat (2) @(posedge tcb_wrc);
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule: uart_tb

// File: verif/uart_tb_clk.sv
// Free-running 20 ns clock; rst_n is synchronous, low for the first 5 rising edges
`timescale 1ns/1ps

module uart_tb_clk (
  output logic tcb_wrc,
  output logic rst_n
);

  initial begin
    tcb_wrc = 1'b0;
    forever #10 tcb_wrc = ~tcb_wrc;  // 50 MHz
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge tcb_wrc);
    rst_n <= 1'b1;  // Released on an edge like any other input
  end

endmodule: uart_tb_clk
